/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f sim.f -o dcache_sim

out=$(./obj_dir/dcache_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

/* sim.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_frames.sv
verilog/dcache_lookup.sv
verilog/dcache_line_refill.sv
verilog/dcache_commit.sv
verilog/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

/* verification/dcache_mem_model.sv */
`timescale 1ns/1ns

module dcache_mem_model import dcache_pkg::*; #(
    parameter integer seed_init = 1
) (
    input  logic    CLK,
    input  logic    reset,
    input  logic    mem_valid,
    output logic    mem_ready,
    input  logic    mem_write,
    input  word_t   mem_addr,
    input  word_t   mem_wdata,
    output word_t   mem_rdata,
    // Shadow memory word at the current mem_addr
    input  word_t   wb_expect,
    output int      mem_errors,
    output int      wb_count
);

    word_t          mem [word_t];
    integer         seed;
    logic           xfer;
    logic [1:0]     wait_left;
    int             r;

    // Start-up contents, every address bit takes part
    function automatic word_t fill_pattern(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t read_word(input word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_pattern(a);
    endfunction

    initial begin
        seed       = seed_init;
        mem_ready  = 1'b0;
        mem_rdata  = '0;
        mem_errors = 0;
        wb_count   = 0;
        wait_left  = 2'd0;
        forever begin
            // Both high at mid cycle means a transfer on the next edge
            @(negedge CLK);
            xfer = !reset && mem_valid && mem_ready;
            if (xfer) begin
                assert (mem_addr[1:0] == 2'b00) else begin
                    mem_errors++;
                    $display("Memory address %h is not word aligned", mem_addr);
                end
            end
            if (xfer && mem_write) begin
                wb_count++;
                assert (mem_wdata == wb_expect) else begin
                    mem_errors++;
                    $display("FAIL t=%0t mem_wdata got %h expected %h", $time,
                             mem_wdata, wb_expect);
                end
                mem[mem_addr] = mem_wdata;
            end
            @(posedge CLK);
            #2;
            // New wait of 0 to 3 cycles after each transfer
            if (xfer) begin
                r         = $random(seed);
                wait_left = r[1:0];
                mem_ready = 1'b0;
            end
            if (!mem_ready) begin
                if (wait_left == 2'd0) begin
                    mem_ready = 1'b1;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
            mem_rdata = read_word(mem_addr);
        end
    end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam integer seed_value    = 6693;
    localparam int     req_timeout   = 200;
    localparam int     drain_timeout = 4000;

    typedef struct packed {
        logic           write;
        dcache_addr_t   addr;
        word_t          wdata;
    } req_t;

    logic           CLK;
    logic           reset;
    logic           cpu_req_valid;
    logic           cpu_req_ready;
    logic           cpu_req_write;
    dcache_addr_t   cpu_req_addr;
    word_t          cpu_req_wdata;
    logic           cpu_resp_valid;
    logic           cpu_resp_ready;
    word_t          cpu_resp_rdata;
    logic           cpu_resp_hit;
    logic           mem_valid;
    logic           mem_ready;
    logic           mem_write;
    word_t          mem_addr;
    word_t          mem_wdata;
    word_t          mem_rdata;
    word_t          wb_expect;
    int             mem_errors;
    int             wb_count;

    integer         seed;
    logic           stall_mode;
    int             check_errors;
    int             timeouts;
    req_t           req_q [$];

    // Shadow memory of retired stores by word address
    word_t                      shadow [word_t];
    logic                       ref_valid [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_TAG_W-1:0]   ref_tag   [`DCACHE_WAYS][`DCACHE_SETS];
    logic                       ref_lru   [`DCACHE_SETS];

    dcache_top dut_i (.*);

    dcache_mem_model #(.seed_init(seed_value)) mem_i (
        .CLK        (CLK),
        .reset      (reset),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .wb_expect  (wb_expect),
        .mem_errors (mem_errors),
        .wb_count   (wb_count)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // Same start-up contents as the memory model
    function automatic word_t fill_pattern(input word_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t shadow_word(input word_t key);
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return fill_pattern(key);
    endfunction

    function automatic dcache_addr_t make_addr(input int tag, input int idx, input int blk,
                                               input int bytoff);
        dcache_addr_t a;
        a.tag    = tag[`DCACHE_TAG_W-1:0];
        a.idx    = idx[`DCACHE_IDX_W-1:0];
        a.blkoff = blk[0];
        a.bytoff = bytoff[1:0];
        return a;
    endfunction

    function automatic int pool_tag(input logic [1:0] sel);
        case (sel)
            2'd0: return 1;
            2'd1: return 2;
            2'd2: return 3;
            default: return 32'h2ab_cdef;
        endcase
    endfunction

    // Expected {hit, rdata} for one request in retire order
    function automatic logic [32:0] reference_result(input req_t req);
        dcache_addr_t   a;
        word_t          key;
        logic           hit;
        logic           way;
        word_t          data;
        a   = req.addr;
        key = {a.tag, a.idx, a.blkoff, 2'b00};
        hit = 1'b0;
        way = ref_lru[a.idx];
        if (ref_valid[0][a.idx] && ref_tag[0][a.idx] == a.tag) begin
            hit = 1'b1;
            way = 1'b0;
        end else if (ref_valid[1][a.idx] && ref_tag[1][a.idx] == a.tag) begin
            hit = 1'b1;
            way = 1'b1;
        end
        // Miss replaces the LRU way
        if (!hit) begin
            ref_valid[way][a.idx] = 1'b1;
            ref_tag[way][a.idx]   = a.tag;
        end
        ref_lru[a.idx] = ~way;
        if (req.write) begin
            shadow[key] = req.wdata;
            data        = req.wdata;
        end else begin
            data = shadow_word(key);
        end
        return {hit, data};
    endfunction

    task automatic report_and_finish();
        $display("Errors: response checks %0d, memory checks %0d, timeouts %0d",
                 check_errors, mem_errors, timeouts);
        if (check_errors + mem_errors + timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Runs from 2 ns after an edge to 2 ns after the transfer edge
    task automatic issue(input logic write, input dcache_addr_t addr, input word_t wdata);
        int cycles;
        cpu_req_valid = 1'b1;
        cpu_req_write = write;
        cpu_req_addr  = addr;
        cpu_req_wdata = wdata;
        cycles = 0;
        @(negedge CLK);
        while (!cpu_req_ready && cycles < req_timeout) begin
            cycles++;
            @(negedge CLK);
        end
        if (!cpu_req_ready) begin
            timeouts++;
            $display("Timeout: request to %h was never accepted", addr);
            report_and_finish();
        end else begin
            @(posedge CLK);
            #2;
            req_q.push_back('{write: write, addr: addr, wdata: wdata});
            cpu_req_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (req_q.size() != 0 && cycles < drain_timeout) begin
            @(posedge CLK);
            cycles++;
        end
        if (req_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d responses never arrived", req_q.size());
            report_and_finish();
        end else begin
            @(posedge CLK);
            #2;
        end
    endtask

    task automatic check_response();
        req_t           req;
        logic [32:0]    expected;
        if (req_q.size() == 0) begin
            check_errors++;
            $display("Response arrived with no request outstanding");
        end else begin
            req      = req_q.pop_front();
            expected = reference_result(req);
            assert (cpu_resp_rdata == expected[31:0]) else begin
                check_errors++;
                $display("FAIL t=%0t cpu_resp_rdata got %h expected %h", $time,
                         cpu_resp_rdata, expected[31:0]);
            end
            assert (cpu_resp_hit == expected[32]) else begin
                check_errors++;
                $display("FAIL t=%0t cpu_resp_hit got %b expected %b", $time,
                         cpu_resp_hit, expected[32]);
            end
        end
    endtask

    // Shadow word at mem_addr for the write-back check
    always @(posedge CLK) begin
        #2;
        wb_expect = shadow_word(mem_addr);
    end

    // Response side with optional back-pressure
    initial begin
        integer ready_seed;
        int     r;
        ready_seed     = seed_value;
        cpu_resp_ready = 1'b1;
        forever begin
            @(negedge CLK);
            if (!reset && cpu_resp_valid && cpu_resp_ready) begin
                check_response();
            end
            @(posedge CLK);
            #2;
            r = $random(ready_seed);
            cpu_resp_ready = !stall_mode || (r[1:0] != 2'b00);
        end
    end

    initial begin
        int r;
        seed          = seed_value;
        reset         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        stall_mode    = 1'b0;
        check_errors  = 0;
        timeouts      = 0;
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        repeat (5) @(posedge CLK);
        #2;
        reset = 1'b0;

        assert (cpu_req_ready && !cpu_resp_valid && !mem_valid) else begin
            check_errors++;
            $display("Port state after reset is not idle");
        end

        // Read miss then a hit on the same line
        issue(1'b0, make_addr(1, 0, 0, 0), '0);
        issue(1'b0, make_addr(1, 0, 1, 0), '0);
        // Store hit and load back
        issue(1'b1, make_addr(1, 0, 0, 0), 32'hc0de_0001);
        issue(1'b0, make_addr(1, 0, 0, 0), '0);
        // Store miss allocates the line
        issue(1'b1, make_addr(2, 1, 1, 0), 32'h570e_0003);
        issue(1'b0, make_addr(2, 1, 0, 0), '0);
        issue(1'b0, make_addr(2, 1, 1, 0), '0);
        // Third tag on set 2 evicts the dirty line
        issue(1'b1, make_addr(1, 2, 0, 0), 32'hd1d1_0000);
        issue(1'b1, make_addr(1, 2, 1, 0), 32'hd1d1_0001);
        issue(1'b0, make_addr(2, 2, 0, 0), '0);
        issue(1'b0, make_addr(3, 2, 0, 0), '0);
        issue(1'b0, make_addr(1, 2, 0, 0), '0);
        issue(1'b0, make_addr(1, 2, 1, 0), '0);
        drain();
        assert (wb_count == 2) else begin
            check_errors++;
            $display("FAIL t=%0t wb_count got %0d expected 2", $time, wb_count);
        end

        // LRU order A B A C then A hits and B misses
        issue(1'b0, make_addr(1, 3, 0, 0), '0);
        issue(1'b0, make_addr(2, 3, 0, 0), '0);
        issue(1'b0, make_addr(1, 3, 0, 0), '0);
        issue(1'b0, make_addr(3, 3, 0, 0), '0);
        issue(1'b0, make_addr(1, 3, 0, 0), '0);
        issue(1'b0, make_addr(2, 3, 0, 0), '0);
        drain();

        // Random mix with response stalls
        stall_mode = 1'b1;
        repeat (400) begin
            r = $random(seed);
            issue(r[0], make_addr(pool_tag(r[2:1]), int'(r[5:3]), int'(r[6]), int'(r[8:7])),
                  $random(seed));
            if (r[9]) begin
                @(posedge CLK);
                #2;
            end
        end
        drain();
        report_and_finish();
    end

endmodule

/* verilog/dcache_commit.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_commit import dcache_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    // From lookup
    input  logic                                lk_valid,
    output logic                                lk_ready,
    input  logic                                lk_write,
    input  dcache_addr_t                        lk_addr,
    input  word_t                               lk_wdata,
    input  logic                                lk_hit,
    input  way_t                                lk_way,
    input  dcache_frame_t [`DCACHE_WAYS-1:0]    rd_frames,
    input  way_t                                rd_lru,
    // Word write port
    output logic                                wr_en,
    output way_t                                wr_way,
    output logic [`DCACHE_IDX_W-1:0]            wr_idx,
    output logic [`DCACHE_BLKOFF_W-1:0]         wr_blkoff,
    output word_t                               wr_data,
    output logic                                wr_dirty,
    output logic                                lru_touch,
    // Fill port
    output logic                                fill_en,
    output way_t                                fill_way,
    output logic [`DCACHE_IDX_W-1:0]            fill_idx,
    output logic [`DCACHE_TAG_W-1:0]            fill_tag,
    output word_t                               fill_word,
    // Memory port
    output logic                                mem_valid,
    input  logic                                mem_ready,
    output logic                                mem_write,
    output word_t                               mem_addr,
    output word_t                               mem_wdata,
    input  word_t                               mem_rdata,
    // Processor response port
    output logic                                cpu_resp_valid,
    input  logic                                cpu_resp_ready,
    output word_t                               cpu_resp_rdata,
    output logic                                cpu_resp_hit
);

    logic                               occ_q;
    logic                               started_q;
    logic                               filled_q;
    logic                               write_q;
    logic                               hit_q;
    dcache_addr_t                       addr_q;
    word_t                              wdata_q;
    way_t                               way_q;
    dcache_frame_t [`DCACHE_WAYS-1:0]   frames_q;
    logic                               start;
    logic                               done;
    logic                               retire;

    assign lk_ready       = ~occ_q;
    assign start          = occ_q & ~hit_q & ~started_q;
    assign cpu_resp_valid = occ_q & (hit_q | filled_q);
    assign retire         = cpu_resp_valid & cpu_resp_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            occ_q     <= 1'b0;
            started_q <= 1'b0;
            filled_q  <= 1'b0;
        end else if (retire) begin
            occ_q     <= 1'b0;
            started_q <= 1'b0;
            filled_q  <= 1'b0;
        end else begin
            if (lk_valid && lk_ready) begin
                occ_q <= 1'b1;
            end
            if (start) begin
                started_q <= 1'b1;
            end
            if (done) begin
                filled_q <= 1'b1;
            end
        end
    end

    // Set snapshot taken on accept; rd_idx moves on to the next item
    always_ff @(posedge CLK) begin
        if (lk_valid && lk_ready) begin
            write_q  <= lk_write;
            hit_q    <= lk_hit;
            addr_q   <= lk_addr;
            wdata_q  <= lk_wdata;
            way_q    <= lk_hit ? lk_way : rd_lru;
            frames_q <= rd_frames;
        end else if (fill_en) begin
            // Mirror the fill so the load can answer from the new line
            frames_q[way_q].data <=
                {fill_word, frames_q[way_q].data[`DCACHE_LINE_WORDS-1:1]};
        end
    end

    assign cpu_resp_hit   = hit_q;
    assign cpu_resp_rdata = write_q ? wdata_q : frames_q[way_q].data[addr_q.blkoff];

    // Array update on the response edge
    assign wr_en     = retire & write_q;
    assign wr_way    = way_q;
    assign wr_idx    = addr_q.idx;
    assign wr_blkoff = addr_q.blkoff;
    assign wr_data   = wdata_q;
    assign wr_dirty  = write_q;
    assign lru_touch = retire;

    dcache_line_refill refill_i (
        .CLK          (CLK),
        .reset        (reset),
        .start        (start),
        .victim_frame (frames_q[way_q]),
        .victim_way   (way_q),
        .new_addr     (addr_q),
        .done         (done),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_idx     (fill_idx),
        .fill_tag     (fill_tag),
        .fill_word    (fill_word),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata)
    );

endmodule

/* verilog/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Data word and address split
`define DCACHE_WORD_W      32
`define DCACHE_TAG_W       26
`define DCACHE_IDX_W       3
`define DCACHE_BLKOFF_W    1
`define DCACHE_BYTOFF_W    2

// Cache geometry
`define DCACHE_SETS        8
`define DCACHE_LINE_WORDS  2
`define DCACHE_WAYS        2

`endif

/* verilog/dcache_frames.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_frames import dcache_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    // Live read port for the lookup stage
    input  logic [`DCACHE_IDX_W-1:0]            rd_idx,
    output dcache_frame_t [`DCACHE_WAYS-1:0]    rd_frames,
    output way_t                                rd_lru,
    // Word write port from commit
    input  logic                                wr_en,
    input  way_t                                wr_way,
    input  logic [`DCACHE_IDX_W-1:0]            wr_idx,
    input  logic [`DCACHE_BLKOFF_W-1:0]         wr_blkoff,
    input  word_t                               wr_data,
    input  logic                                wr_dirty,
    input  logic                                lru_touch,
    // Line fill port from the refill unit
    input  logic                                fill_en,
    input  way_t                                fill_way,
    input  logic [`DCACHE_IDX_W-1:0]            fill_idx,
    input  logic [`DCACHE_TAG_W-1:0]            fill_tag,
    input  word_t                               fill_word
);

    logic                               valid_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic                               dirty_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_TAG_W-1:0]           tag_q   [`DCACHE_WAYS][`DCACHE_SETS];
    word_t [`DCACHE_LINE_WORDS-1:0]     data_q  [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]            lru_q;

    // Combinational read of both ways at the requested set
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            rd_frames[w].valid = valid_q[w][rd_idx];
            rd_frames[w].dirty = dirty_q[w][rd_idx];
            rd_frames[w].tag   = tag_q[w][rd_idx];
            rd_frames[w].data  = data_q[w][rd_idx];
        end
    end

    assign rd_lru = lru_q[rd_idx];

    // Valid, dirty and LRU state
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
            lru_q <= '0;
        end else begin
            // A filled line starts out clean
            if (fill_en) begin
                valid_q[fill_way][fill_idx] <= 1'b1;
                dirty_q[fill_way][fill_idx] <= 1'b0;
            end
            if (wr_en) begin
                dirty_q[wr_way][wr_idx] <= wr_dirty;
            end
            // LRU points at the way not just used
            if (lru_touch) begin
                lru_q[wr_idx] <= ~wr_way;
            end
        end
    end

    // Tags and data
    always_ff @(posedge CLK) begin
        if (fill_en) begin
            tag_q[fill_way][fill_idx] <= fill_tag;
            // Words arrive in blkoff order and shift in from the top
            data_q[fill_way][fill_idx] <=
                {fill_word, data_q[fill_way][fill_idx][`DCACHE_LINE_WORDS-1:1]};
        end
        if (wr_en) begin
            data_q[wr_way][wr_idx][wr_blkoff] <= wr_data;
        end
    end

endmodule

/* verilog/dcache_line_refill.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_line_refill import dcache_pkg::*; (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic                        start,
    input  dcache_frame_t               victim_frame,
    input  way_t                        victim_way,
    input  dcache_addr_t                new_addr,
    output logic                        done,
    // Fill port
    output logic                        fill_en,
    output way_t                        fill_way,
    output logic [`DCACHE_IDX_W-1:0]    fill_idx,
    output logic [`DCACHE_TAG_W-1:0]    fill_tag,
    output word_t                       fill_word,
    // Memory port
    output logic                        mem_valid,
    input  logic                        mem_ready,
    output logic                        mem_write,
    output word_t                       mem_addr,
    output word_t                       mem_wdata,
    input  word_t                       mem_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_wb0,
        st_wb1,
        st_fetch0,
        st_fetch1,
        st_done
    } state_t;

    state_t                         state_q;
    state_t                         state_d;
    logic [`DCACHE_BLKOFF_W-1:0]    blk;
    logic                           fetching;
    dcache_addr_t                   wb_addr;
    dcache_addr_t                   fetch_addr;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                // Only a valid dirty victim goes back to memory
                if (start) begin
                    if (victim_frame.valid && victim_frame.dirty) begin
                        state_d = st_wb0;
                    end else begin
                        state_d = st_fetch0;
                    end
                end
            end
            st_wb0: begin
                if (mem_ready) begin
                    state_d = st_wb1;
                end
            end
            st_wb1: begin
                if (mem_ready) begin
                    state_d = st_fetch0;
                end
            end
            st_fetch0: begin
                if (mem_ready) begin
                    state_d = st_fetch1;
                end
            end
            st_fetch1: begin
                if (mem_ready) begin
                    state_d = st_done;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign blk      = (state_q == st_wb1) || (state_q == st_fetch1);
    assign fetching = (state_q == st_fetch0) || (state_q == st_fetch1);

    // Victim goes back at its own tag, same set
    assign wb_addr    = '{tag: victim_frame.tag, idx: new_addr.idx, blkoff: blk, bytoff: '0};
    assign fetch_addr = '{tag: new_addr.tag, idx: new_addr.idx, blkoff: blk, bytoff: '0};

    assign mem_write = (state_q == st_wb0) || (state_q == st_wb1);
    assign mem_valid = mem_write | fetching;
    assign mem_addr  = mem_write ? wb_addr : fetch_addr;
    assign mem_wdata = victim_frame.data[blk];

    // Fetched word is written on its transfer edge
    assign fill_en   = fetching & mem_ready;
    assign fill_way  = victim_way;
    assign fill_idx  = new_addr.idx;
    assign fill_tag  = new_addr.tag;
    assign fill_word = mem_rdata;

    assign done = (state_q == st_done);

endmodule

/* verilog/dcache_lookup.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_lookup import dcache_pkg::*; (
    input  logic                                CLK,
    input  logic                                reset,
    // Processor request port
    input  logic                                cpu_req_valid,
    output logic                                cpu_req_ready,
    input  logic                                cpu_req_write,
    input  dcache_addr_t                        cpu_req_addr,
    input  word_t                               cpu_req_wdata,
    // Frame array read
    output logic [`DCACHE_IDX_W-1:0]            rd_idx,
    input  dcache_frame_t [`DCACHE_WAYS-1:0]    rd_frames,
    // Toward commit
    output logic                                lk_valid,
    input  logic                                lk_ready,
    output logic                                lk_write,
    output dcache_addr_t                        lk_addr,
    output word_t                               lk_wdata,
    output logic                                lk_hit,
    output way_t                                lk_way
);

    logic                       occ_q;
    logic                       write_q;
    dcache_addr_t               addr_q;
    word_t                      wdata_q;
    logic [`DCACHE_WAYS-1:0]    match;

    // Free slot, or the held item moves on this edge
    assign cpu_req_ready = ~occ_q | lk_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            occ_q <= 1'b0;
        end else if (cpu_req_ready) begin
            occ_q <= cpu_req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (cpu_req_valid && cpu_req_ready) begin
            write_q <= cpu_req_write;
            addr_q  <= cpu_req_addr;
            wdata_q <= cpu_req_wdata;
        end
    end

    assign rd_idx = addr_q.idx;

    // Compared every cycle, so a held item sees earlier retires
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            match[w] = rd_frames[w].valid && (rd_frames[w].tag == addr_q.tag);
        end
    end

    assign lk_valid = occ_q;
    assign lk_write = write_q;
    assign lk_addr  = addr_q;
    assign lk_wdata = wdata_q;
    assign lk_hit   = |match;
    assign lk_way   = match[1];

endmodule

/* verilog/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // One-bit way select, also used for the per-set LRU bit
    typedef logic way_t;

    // Word address as seen by the cache, byte offset ignored
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_IDX_W-1:0]    idx;
        logic [`DCACHE_BLKOFF_W-1:0] blkoff;
        logic [`DCACHE_BYTOFF_W-1:0] bytoff;
    } dcache_addr_t;

    // One way of one set
    typedef struct packed {
        logic                                valid;
        logic                                dirty;
        logic [`DCACHE_TAG_W-1:0]            tag;
        word_t [`DCACHE_LINE_WORDS-1:0]      data;
    } dcache_frame_t;

endpackage

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_top import dcache_pkg::*; (
    input  logic            CLK,
    input  logic            reset,
    // Processor request port
    input  logic            cpu_req_valid,
    output logic            cpu_req_ready,
    input  logic            cpu_req_write,
    input  dcache_addr_t    cpu_req_addr,
    input  word_t           cpu_req_wdata,
    // Processor response port
    output logic            cpu_resp_valid,
    input  logic            cpu_resp_ready,
    output word_t           cpu_resp_rdata,
    output logic            cpu_resp_hit,
    // Memory port
    output logic            mem_valid,
    input  logic            mem_ready,
    output logic            mem_write,
    output word_t           mem_addr,
    output word_t           mem_wdata,
    input  word_t           mem_rdata
);

    // Frame array read
    logic [`DCACHE_IDX_W-1:0]           rd_idx;
    dcache_frame_t [`DCACHE_WAYS-1:0]   rd_frames;
    way_t                               rd_lru;

    // Lookup to commit
    logic                               lk_valid;
    logic                               lk_ready;
    logic                               lk_write;
    dcache_addr_t                       lk_addr;
    word_t                              lk_wdata;
    logic                               lk_hit;
    way_t                               lk_way;

    // Word write port
    logic                               wr_en;
    way_t                               wr_way;
    logic [`DCACHE_IDX_W-1:0]           wr_idx;
    logic [`DCACHE_BLKOFF_W-1:0]        wr_blkoff;
    word_t                              wr_data;
    logic                               wr_dirty;
    logic                               lru_touch;

    // Fill port
    logic                               fill_en;
    way_t                               fill_way;
    logic [`DCACHE_IDX_W-1:0]           fill_idx;
    logic [`DCACHE_TAG_W-1:0]           fill_tag;
    word_t                              fill_word;

    dcache_frames frames_i (.*);

    dcache_lookup lookup_i (.*);

    dcache_commit commit_i (.*);

endmodule
